// File: include/unwrap_macros.svh
/* Burst unwrapper parameters
   Bus field widths and the depth of the outstanding-read length queue */

`ifndef UNWRAP_MACROS_SVH
`define UNWRAP_MACROS_SVH

// AXI read field widths
`define UNWRAP_ADDR_W 32
`define UNWRAP_DATA_W 32
`define UNWRAP_ID_W   4
`define UNWRAP_USER_W 2

// Upstream reads that may be outstanding at once
`define UNWRAP_LENQ_DEPTH 4

`endif

// File: hdl/unwrap_pkg.sv
/* Burst unwrapper types
   AXI read field types, burst encoding and the AR channel struct */

`default_nettype none

`include "unwrap_macros.svh"

package unwrap_pkg;

  typedef logic [`UNWRAP_ADDR_W-1:0] addr_t;
  typedef logic [`UNWRAP_DATA_W-1:0] data_t;
  typedef logic [`UNWRAP_ID_W-1:0]   id_t;
  typedef logic [`UNWRAP_USER_W-1:0] user_t;

  // Beats in a burst are len + 1
  typedef logic [7:0] len_t;
  // log2 of the beat size in bytes
  typedef logic [2:0] size_t;
  typedef logic [1:0] resp_t;

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1,
    WRAP  = 2'd2
  } burst_e;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_e burst;
    user_t  user;
  } ar_chan_t;

endpackage

`default_nettype wire

// File: hdl/burst_len_if.sv
/* Burst length link
   Carries upstream burst lengths from the AR splitter to the R tracker */

`timescale 1ns/10ps
`default_nettype none

interface burst_len_if import unwrap_pkg::*; ();

  // Producer side
  logic push;
  len_t push_len;
  logic full;

  // Consumer side
  len_t head_len;
  logic empty;
  logic pop;

  modport producer (output push, output push_len, input full);

  modport queue (input push, input push_len, input pop,
                 output full, output head_len, output empty);

  modport consumer (output pop, input head_len, input empty);

endinterface

`default_nettype wire

// File: hdl/ar_wrap_splitter.sv
/* AR wrap splitter
   Turns upstream read requests into INCR bursts, splitting misaligned WRAPs in two */

`timescale 1ns/10ps
`default_nettype none

module ar_wrap_splitter import unwrap_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire ar_chan_t ar_i,
  input  wire logic     ar_valid_i,
  output logic          ar_ready_o,
  output ar_chan_t      ar_o,
  output logic          ar_valid_o,
  input  wire logic     ar_ready_i,
  burst_len_if.producer len_q
);

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e   state_q, state_d;
  ar_chan_t second_q;
  logic     second_load;

  addr_t container_size;
  addr_t wrap_boundary;
  addr_t first_beats;
  addr_t second_beats;
  logic  split_needed;

  // ----------------------------------------------------------------------
  // Wrap geometry
  // ----------------------------------------------------------------------
  // Container is a power of two for legal WRAP lengths
  assign container_size = (addr_t'(ar_i.len) + addr_t'(1)) << ar_i.size;
  assign wrap_boundary  = ar_i.addr & ~(container_size - addr_t'(1));
  assign first_beats    = (wrap_boundary + container_size - ar_i.addr) >> ar_i.size;
  assign second_beats   = (ar_i.addr - wrap_boundary) >> ar_i.size;
  assign split_needed   = (ar_i.burst == WRAP) && (ar_i.addr != wrap_boundary);

  // ----------------------------------------------------------------------
  // Request control
  // ----------------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    second_load    = 1'b0;
    ar_o           = ar_i;
    ar_valid_o     = 1'b0;
    ar_ready_o     = 1'b0;
    len_q.push     = 1'b0;
    len_q.push_len = ar_i.len;

    case (state_q)
      IDLE: begin
        if (split_needed) begin
          // First part runs up to the top of the container
          ar_o.burst = INCR;
          ar_o.len   = len_t'(first_beats - addr_t'(1));
        end else if (ar_i.burst == WRAP) begin
          ar_o.burst = INCR;
        end
        // No offer without room to track the upstream burst
        if (ar_valid_i && !len_q.full) begin
          ar_valid_o = 1'b1;
          if (ar_ready_i) begin
            ar_ready_o = 1'b1;
            len_q.push = 1'b1;
            if (split_needed) begin
              second_load = 1'b1;
              state_d     = BUSY;
            end
          end
        end
      end
      BUSY: begin
        ar_o       = second_q;
        ar_valid_o = 1'b1;
        if (ar_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Second part wraps back from the boundary to the start address
  always_ff @(posedge clk_i) begin
    if (second_load) begin
      second_q       <= ar_i;
      second_q.burst <= INCR;
      second_q.addr  <= wrap_boundary;
      second_q.len   <= len_t'(second_beats - addr_t'(1));
    end
  end

endmodule

`default_nettype wire

// File: hdl/burst_len_queue.sv
/* Burst length queue
   In-order FIFO of upstream burst lengths for reads still in flight */

`timescale 1ns/10ps
`default_nettype none

`include "unwrap_macros.svh"

module burst_len_queue import unwrap_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  arst_n_i,
  burst_len_if.queue len_q
);

  localparam int unsigned DEPTH = `UNWRAP_LENQ_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  len_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign len_q.full     = (count_q == CNT_W'(DEPTH));
  assign len_q.empty    = (count_q == '0);
  assign len_q.head_len = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (len_q.push) begin
      mem[wr_ptr_q] <= len_q.push_len;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (len_q.push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (len_q.pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      case ({len_q.push, len_q.pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/r_last_tracker.sv
/* R last tracker
   Counts read beats and rebuilds one last flag per upstream burst */

`timescale 1ns/10ps
`default_nettype none

module r_last_tracker import unwrap_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  // Downstream handshake
  input  wire logic     r_valid_i,
  output logic          r_ready_o,
  // Upstream handshake
  output logic          r_valid_o,
  input  wire logic     r_ready_i,
  output logic          r_last_o,
  burst_len_if.consumer len_q
);

  len_t beat_cnt_q;
  logic xfer;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  // Beats only pass while a tracked burst is open
  assign r_valid_o = r_valid_i && !len_q.empty;
  assign r_ready_o = r_ready_i && !len_q.empty;
  assign xfer      = r_valid_o && r_ready_i;

  // Final beat of the upstream burst, downstream last is not used
  assign r_last_o  = !len_q.empty && (beat_cnt_q == len_q.head_len);
  assign len_q.pop = xfer && r_last_o;

  // ----------------------------------------------------------------------
  // Beat counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (len_q.pop) begin
      beat_cnt_q <= '0;
    end else if (xfer) begin
      beat_cnt_q <= beat_cnt_q + len_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: hdl/burst_unwrap_top.sv
/* Burst unwrapper, read half
   Splits wrapping AR bursts into INCR bursts and restores R last upstream */

`timescale 1ns/10ps
`default_nettype none

module burst_unwrap_top import unwrap_pkg::*; (
  input  wire logic   clk_i,
  input  wire logic   arst_n_i,
  // Upstream AR
  input  wire id_t    s_ar_id_i,
  input  wire addr_t  s_ar_addr_i,
  input  wire len_t   s_ar_len_i,
  input  wire size_t  s_ar_size_i,
  input  wire burst_e s_ar_burst_i,
  input  wire user_t  s_ar_user_i,
  input  wire logic   s_ar_valid_i,
  output logic        s_ar_ready_o,
  // Upstream R
  output id_t         s_r_id_o,
  output data_t       s_r_data_o,
  output resp_t       s_r_resp_o,
  output logic        s_r_last_o,
  output user_t       s_r_user_o,
  output logic        s_r_valid_o,
  input  wire logic   s_r_ready_i,
  // Downstream AR
  output id_t         m_ar_id_o,
  output addr_t       m_ar_addr_o,
  output len_t        m_ar_len_o,
  output size_t       m_ar_size_o,
  output burst_e      m_ar_burst_o,
  output user_t       m_ar_user_o,
  output logic        m_ar_valid_o,
  input  wire logic   m_ar_ready_i,
  // Downstream R
  input  wire id_t    m_r_id_i,
  input  wire data_t  m_r_data_i,
  input  wire resp_t  m_r_resp_i,
  input  wire logic   m_r_last_i,
  input  wire user_t  m_r_user_i,
  input  wire logic   m_r_valid_i,
  output logic        m_r_ready_o
);

  ar_chan_t s_ar;
  ar_chan_t m_ar;

  burst_len_if len_link ();

  // ----------------------------------------------------------------------
  // AR path
  // ----------------------------------------------------------------------
  assign s_ar = '{
    id:    s_ar_id_i,
    addr:  s_ar_addr_i,
    len:   s_ar_len_i,
    size:  s_ar_size_i,
    burst: s_ar_burst_i,
    user:  s_ar_user_i
  };

  assign m_ar_id_o    = m_ar.id;
  assign m_ar_addr_o  = m_ar.addr;
  assign m_ar_len_o   = m_ar.len;
  assign m_ar_size_o  = m_ar.size;
  assign m_ar_burst_o = m_ar.burst;
  assign m_ar_user_o  = m_ar.user;

  ar_wrap_splitter ar_wrap_splitter_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ar_i       (s_ar),
    .ar_valid_i (s_ar_valid_i),
    .ar_ready_o (s_ar_ready_o),
    .ar_o       (m_ar),
    .ar_valid_o (m_ar_valid_o),
    .ar_ready_i (m_ar_ready_i),
    .len_q      (len_link.producer)
  );

  burst_len_queue burst_len_queue_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .len_q    (len_link.queue)
  );

  // ----------------------------------------------------------------------
  // R path
  // ----------------------------------------------------------------------
  // Payload flows straight through, m_r_last_i is left unused
  assign s_r_id_o   = m_r_id_i;
  assign s_r_data_o = m_r_data_i;
  assign s_r_resp_o = m_r_resp_i;
  assign s_r_user_o = m_r_user_i;

  r_last_tracker r_last_tracker_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .r_valid_i (m_r_valid_i),
    .r_ready_o (m_r_ready_o),
    .r_valid_o (s_r_valid_o),
    .r_ready_i (s_r_ready_i),
    .r_last_o  (s_r_last_o),
    .len_q     (len_link.consumer)
  );

endmodule

`default_nettype wire

// File: verification/burst_unwrap_tb.sv
/* Burst unwrapper testbench
   Upstream read master and downstream memory model, driven from a vectors file */

`timescale 1ns/10ps
`default_nettype none

`include "unwrap_macros.svh"

module burst_unwrap_tb import unwrap_pkg::*; ();

  localparam int NUM_VEC     = 10;
  localparam int VEC_W       = 10;
  localparam int TIMEOUT     = 2000;
  localparam int HOLD_CYCLES = 16;
  localparam int DEPTH       = `UNWRAP_LENQ_DEPTH;

  typedef struct packed {
    id_t   id;
    logic  last;
    data_t data;
    resp_t resp;
    user_t user;
  } beat_t;

  logic   clk_i;
  logic   arst_n_i;
  id_t    s_ar_id_i;
  addr_t  s_ar_addr_i;
  len_t   s_ar_len_i;
  size_t  s_ar_size_i;
  burst_e s_ar_burst_i;
  user_t  s_ar_user_i;
  logic   s_ar_valid_i;
  logic   s_ar_ready_o;
  id_t    s_r_id_o;
  data_t  s_r_data_o;
  resp_t  s_r_resp_o;
  logic   s_r_last_o;
  user_t  s_r_user_o;
  logic   s_r_valid_o;
  logic   s_r_ready_i = 1'b0;
  id_t    m_ar_id_o;
  addr_t  m_ar_addr_o;
  len_t   m_ar_len_o;
  size_t  m_ar_size_o;
  burst_e m_ar_burst_o;
  user_t  m_ar_user_o;
  logic   m_ar_valid_o;
  logic   m_ar_ready_i = 1'b0;
  id_t    m_r_id_i = '0;
  data_t  m_r_data_i = '0;
  resp_t  m_r_resp_i = '0;
  logic   m_r_last_i = 1'b0;
  user_t  m_r_user_i = '0;
  logic   m_r_valid_i = 1'b0;
  logic   m_r_ready_o;

  logic [31:0] vec_mem [0:NUM_VEC*VEC_W-1];
  logic [31:0] lfsr_q = 32'h17a9;
  logic        random_mode = 1'b0;
  logic        hold_r = 1'b0;
  logic        timed_out = 1'b0;
  int          err_cnt = 0;
  int          last_cnt = 0;
  int          tests_run = 0;

  ar_chan_t exp_ar_q [$];
  beat_t    exp_beat_q [$];
  ar_chan_t mem_q [$];

  // Memory model and handshake history
  ar_chan_t mem_cur;
  len_t     mem_beat;
  logic     mem_busy = 1'b0;
  logic     r_taken = 1'b0;
  logic     ar_pend = 1'b0;
  logic     r_pend = 1'b0;
  ar_chan_t ar_held;
  beat_t    r_held;

  burst_unwrap_top burst_unwrap_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic random_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // Beat address from the AXI burst rules
  function automatic addr_t beat_addr(input ar_chan_t b, input len_t i);
    addr_t step;
    addr_t span;
    addr_t result;
    step = addr_t'(i) << b.size;
    span = (addr_t'(b.len) + addr_t'(1)) << b.size;
    case (b.burst)
      FIXED:   result = b.addr;
      WRAP:    result = (b.addr & ~(span - addr_t'(1))) | ((b.addr + step) & (span - addr_t'(1)));
      default: result = b.addr + step;
    endcase
    return result;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    err_cnt++;
  endtask

  // --------------------------------------------------------------------
  // Monitor sampling every handshake on the rising edge
  // --------------------------------------------------------------------
  always @(posedge clk_i) begin
    ar_chan_t m_ar;
    ar_chan_t exp_ar;
    beat_t    got_beat;
    beat_t    exp_beat;
    m_ar.id    = m_ar_id_o;
    m_ar.addr  = m_ar_addr_o;
    m_ar.len   = m_ar_len_o;
    m_ar.size  = m_ar_size_o;
    m_ar.burst = m_ar_burst_o;
    m_ar.user  = m_ar_user_o;
    got_beat.id   = s_r_id_o;
    got_beat.last = s_r_last_o;
    got_beat.data = s_r_data_o;
    got_beat.resp = s_r_resp_o;
    got_beat.user = s_r_user_o;
    if (arst_n_i === 1'b1) begin
      if (ar_pend && !m_ar_valid_o) begin
        report_error("downstream AR valid dropped before acceptance");
      end
      if (ar_pend && m_ar_valid_o && m_ar !== ar_held) begin
        report_mismatch("m_ar payload", 64'(m_ar), 64'(ar_held));
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        if (exp_ar_q.size() == 0) begin
          report_error("unexpected downstream AR burst");
        end else begin
          exp_ar = exp_ar_q.pop_front();
          if (m_ar_addr_o !== exp_ar.addr) begin
            report_mismatch("m_ar_addr_o", 64'(m_ar_addr_o), 64'(exp_ar.addr));
          end
          if (m_ar_len_o !== exp_ar.len) begin
            report_mismatch("m_ar_len_o", 64'(m_ar_len_o), 64'(exp_ar.len));
          end
          if (m_ar_burst_o !== exp_ar.burst) begin
            report_mismatch("m_ar_burst_o", 64'(m_ar_burst_o), 64'(exp_ar.burst));
          end
          if (m_ar_id_o !== exp_ar.id) begin
            report_mismatch("m_ar_id_o", 64'(m_ar_id_o), 64'(exp_ar.id));
          end
          if (m_ar_size_o !== exp_ar.size) begin
            report_mismatch("m_ar_size_o", 64'(m_ar_size_o), 64'(exp_ar.size));
          end
          if (m_ar_user_o !== exp_ar.user) begin
            report_mismatch("m_ar_user_o", 64'(m_ar_user_o), 64'(exp_ar.user));
          end
        end
        mem_q.push_back(m_ar);
      end
      ar_pend = m_ar_valid_o && !m_ar_ready_i;
      ar_held = m_ar;

      if (r_pend && !s_r_valid_o) begin
        report_error("upstream R valid dropped before acceptance");
      end
      if (r_pend && s_r_valid_o && got_beat !== r_held) begin
        report_mismatch("s_r payload", 64'(got_beat), 64'(r_held));
      end
      if (s_r_valid_o && s_r_ready_i) begin
        if (exp_beat_q.size() == 0) begin
          report_error("unexpected upstream R beat");
        end else begin
          exp_beat = exp_beat_q.pop_front();
          if (s_r_data_o !== exp_beat.data) begin
            report_mismatch("s_r_data_o", 64'(s_r_data_o), 64'(exp_beat.data));
          end
          if (s_r_last_o !== exp_beat.last) begin
            report_mismatch("s_r_last_o", 64'(s_r_last_o), 64'(exp_beat.last));
          end
          if (s_r_id_o !== exp_beat.id) begin
            report_mismatch("s_r_id_o", 64'(s_r_id_o), 64'(exp_beat.id));
          end
          if (s_r_resp_o !== exp_beat.resp) begin
            report_mismatch("s_r_resp_o", 64'(s_r_resp_o), 64'(exp_beat.resp));
          end
          if (s_r_user_o !== exp_beat.user) begin
            report_mismatch("s_r_user_o", 64'(s_r_user_o), 64'(exp_beat.user));
          end
        end
        if (s_r_last_o) begin
          last_cnt++;
        end
      end
      r_pend  = s_r_valid_o && !s_r_ready_i;
      r_held  = got_beat;
      r_taken = m_r_valid_i && m_r_ready_o;
    end
  end

  // --------------------------------------------------------------------
  // Downstream memory and ready drivers on the falling edge
  // --------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (arst_n_i !== 1'b1) begin
      mem_busy     = 1'b0;
      m_r_valid_i  = 1'b0;
      m_ar_ready_i = 1'b0;
      s_r_ready_i  = 1'b0;
    end else begin
      if (r_taken) begin
        m_r_valid_i = 1'b0;
        if (mem_beat == mem_cur.len) begin
          mem_busy = 1'b0;
        end else begin
          mem_beat = mem_beat + len_t'(1);
        end
      end
      if (!m_r_valid_i) begin
        if (!mem_busy && !hold_r && mem_q.size() != 0) begin
          mem_cur  = mem_q.pop_front();
          mem_beat = '0;
          mem_busy = 1'b1;
        end
        // Random gap of about one beat in four
        if (mem_busy && !(random_mode && random_bit() && random_bit())) begin
          m_r_valid_i = 1'b1;
          m_r_id_i    = mem_cur.id;
          m_r_data_i  = beat_addr(mem_cur, mem_beat);
          // Response code follows the beat address so that it varies
          m_r_resp_i  = resp_t'(m_r_data_i >> 2);
          m_r_user_i  = mem_cur.user;
          m_r_last_i  = random_bit();
        end
      end
      m_ar_ready_i = random_mode ? random_bit() : 1'b1;
      s_r_ready_i  = random_mode ? (random_bit() | random_bit()) : 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Upstream request sequencing
  // --------------------------------------------------------------------
  task automatic offer_request(input int idx);
    ar_chan_t req;
    ar_chan_t part;
    beat_t    beat;
    int       base;
    int       k;
    base      = idx * VEC_W;
    req.id    = id_t'(vec_mem[base]);
    req.addr  = vec_mem[base + 1];
    req.len   = len_t'(vec_mem[base + 2]);
    req.size  = size_t'(vec_mem[base + 3]);
    req.burst = burst_e'(vec_mem[base + 4][1:0]);
    req.user  = user_t'(idx);
    @(negedge clk_i);
    // Downstream bursts are INCR except for FIXED, which passes unchanged
    for (k = 0; k < int'(vec_mem[base + 5]); k++) begin
      part       = req;
      part.burst = (req.burst == FIXED) ? FIXED : INCR;
      part.addr  = vec_mem[base + 6 + 2 * k];
      part.len   = len_t'(vec_mem[base + 7 + 2 * k]);
      exp_ar_q.push_back(part);
    end
    for (k = 0; k <= int'(req.len); k++) begin
      beat.id   = req.id;
      beat.last = (len_t'(k) == req.len);
      beat.data = beat_addr(req, len_t'(k));
      beat.resp = resp_t'(beat.data >> 2);
      beat.user = req.user;
      exp_beat_q.push_back(beat);
    end
    s_ar_id_i    = req.id;
    s_ar_addr_i  = req.addr;
    s_ar_len_i   = req.len;
    s_ar_size_i  = req.size;
    s_ar_burst_i = req.burst;
    s_ar_user_i  = req.user;
    s_ar_valid_i = 1'b1;
  endtask

  task automatic wait_accept();
    int   cycles;
    logic accepted;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < TIMEOUT) begin
      @(posedge clk_i);
      accepted = s_ar_ready_o;
      cycles++;
    end
    if (!accepted) begin
      report_error("upstream AR request was not accepted before the timeout");
      timed_out = 1'b1;
    end
  endtask

  task automatic drop_request();
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_ar_q.size() != 0 || exp_beat_q.size() != 0) && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (exp_ar_q.size() != 0 || exp_beat_q.size() != 0) begin
      report_error("outstanding bursts did not complete before the timeout");
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    tests_run++;
    $display("Test %0d %s finished with %0d errors", num, name, err_cnt - errs_before);
  endtask

  task automatic run_stream_test(input int num, input logic rnd);
    int errs_before;
    int i;
    errs_before = err_cnt;
    @(posedge clk_i);
    random_mode = rnd;
    for (i = 0; i < NUM_VEC && !timed_out; i++) begin
      offer_request(i);
      wait_accept();
    end
    drop_request();
    wait_drained();
    finish_test(num, rnd ? "random ready gaps" : "steady ready", errs_before);
  endtask

  task automatic run_depth_test(input int num);
    int errs_before;
    int i;
    int lasts_before;
    errs_before = err_cnt;
    @(posedge clk_i);
    random_mode = 1'b0;
    hold_r      = 1'b1;
    for (i = 0; i < DEPTH && !timed_out; i++) begin
      offer_request(i);
      wait_accept();
    end
    // The extra request has to wait while the length queue is full
    offer_request(DEPTH);
    for (i = 0; i < HOLD_CYCLES; i++) begin
      @(posedge clk_i);
      if (s_ar_ready_o) begin
        report_error("request accepted while the length queue was full");
      end
    end
    lasts_before = last_cnt;
    hold_r       = 1'b0;
    wait_accept();
    if (last_cnt == lasts_before) begin
      report_error("request accepted before any upstream burst completed");
    end
    drop_request();
    wait_drained();
    finish_test(num, "queue depth limit", errs_before);
  endtask

  initial begin
    arst_n_i     = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = FIXED;
    s_ar_user_i  = '0;
    s_ar_valid_i = 1'b0;
    $readmemh("verification/burst_unwrap_vectors.txt", vec_mem);
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    run_stream_test(1, 1'b0);
    if (!timed_out) begin
      run_stream_test(2, 1'b1);
    end
    if (!timed_out) begin
      run_depth_test(3);
    end

    $display("Summary: %0d tests run, %0d errors", tests_run, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/burst_unwrap_vectors.txt
// id addr len size burst nbursts | first addr len | second addr len, all hex
// burst 0 FIXED, 1 INCR, 2 WRAP; the second pair is zero for a single burst
1 00001000 03 2 1 1 00001000 03 00000000 00
2 00002004 01 2 0 1 00002004 01 00000000 00
3 00003000 03 2 2 1 00003000 03 00000000 00
4 00004008 03 2 2 2 00004008 01 00004000 01
5 0000500c 07 2 2 2 0000500c 04 00005000 02
6 00006008 01 3 2 2 00006008 00 00006000 00
7 00007003 04 0 1 1 00007003 04 00000000 00
8 00008034 0f 2 2 2 00008034 02 00008000 0c
9 00009010 01 3 2 1 00009010 01 00000000 00
a 0000a006 03 1 2 2 0000a006 00 0000a000 02

// File: burst_unwrap_top.f
+incdir+include
hdl/unwrap_pkg.sv
hdl/burst_len_if.sv
hdl/ar_wrap_splitter.sv
hdl/burst_len_queue.sv
hdl/r_last_tracker.sv
hdl/burst_unwrap_top.sv
verification/burst_unwrap_tb.sv

// File: Makefile
# Verilator build and run for the burst unwrapper testbench

TOP             ?= burst_unwrap_tb
FILELIST        ?= burst_unwrap_top.f
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --timing --timescale 1ns/10ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
